//--- design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int XLEN_DEFAULT = 64;
    localparam int REG_ADDR_W   = 5;
    localparam int ILEN         = 32;

    // major opcodes
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    // funct3, shared by register and immediate forms
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    // one instruction word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } instr_t;

endpackage

`default_nettype wire

//--- design/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder #(
    parameter int XLEN = rv_core_pkg::XLEN_DEFAULT
) (
    input  wire rv_core_pkg::instr_t                i_instr,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]      o_rs1,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]      o_rs2,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]      o_rd,
    output logic [rv_core_pkg::ALU_OP_W-1:0]        o_alu_op,
    output logic [XLEN-1:0]                         o_imm,
    output logic                                    o_use_imm,
    output logic                                    o_reg_we
);

    logic [rv_core_pkg::ILEN-1:0] word;
    logic                         alt;
    logic                         supported;

    // bit 30 picks SUB over ADD and SRA over SRL
    function automatic logic [rv_core_pkg::ALU_OP_W-1:0] alu_op_of(
        input logic [2:0] f3,
        input logic       alt_bit,
        input logic       is_reg
    );
        logic [rv_core_pkg::ALU_OP_W-1:0] op;
        case (f3)
            rv_core_pkg::FUNCT3_ADD_SUB: op = (is_reg && alt_bit) ? rv_core_pkg::ALU_SUB
                                                                  : rv_core_pkg::ALU_ADD;
            rv_core_pkg::FUNCT3_SLL:     op = rv_core_pkg::ALU_SLL;
            rv_core_pkg::FUNCT3_SLT:     op = rv_core_pkg::ALU_SLT;
            rv_core_pkg::FUNCT3_SLTU:    op = rv_core_pkg::ALU_SLTU;
            rv_core_pkg::FUNCT3_XOR:     op = rv_core_pkg::ALU_XOR;
            rv_core_pkg::FUNCT3_SRL_SRA: op = alt_bit ? rv_core_pkg::ALU_SRA
                                                      : rv_core_pkg::ALU_SRL;
            rv_core_pkg::FUNCT3_OR:      op = rv_core_pkg::ALU_OR;
            default:                     op = rv_core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign word = i_instr;
    assign alt  = word[30];

    always_comb begin
        supported = 1'b1;
        o_rs1     = i_instr.r.rs1;
        o_rs2     = '0;
        o_imm     = '0;
        o_use_imm = 1'b1;
        o_alu_op  = rv_core_pkg::ALU_PASS_B;
        case (i_instr.r.opcode)
            rv_core_pkg::OP_REG: begin
                o_rs2     = i_instr.r.rs2;
                o_use_imm = 1'b0;
                o_alu_op  = alu_op_of(i_instr.r.funct3, alt, 1'b1);
            end
            rv_core_pkg::OP_IMM: begin
                o_rs1    = i_instr.i.rs1;
                o_imm    = XLEN'($signed(i_instr.i.imm));
                o_alu_op = alu_op_of(i_instr.i.funct3, alt, 1'b0);
            end
            rv_core_pkg::OP_LUI: begin
                // x0 + imm, sign extended from bit 31
                o_rs1 = '0;
                o_imm = XLEN'($signed({i_instr.u.imm, 12'b0}));
            end
            default: begin
                // retires as a no-op, pass of a zero immediate
                supported = 1'b0;
                o_rs1     = '0;
            end
        endcase
    end

    assign o_rd     = i_instr.r.rd;
    assign o_reg_we = supported && (o_rd != '0);

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile #(
    parameter int XLEN = rv_core_pkg::XLEN_DEFAULT
) (
    input  wire                                 clk,
    input  wire                                 i_reset,
    input  wire                                 i_we,
    input  wire [rv_core_pkg::REG_ADDR_W-1:0]   i_waddr,
    input  wire [XLEN-1:0]                      i_wdata,
    input  wire [rv_core_pkg::REG_ADDR_W-1:0]   i_raddr1,
    input  wire [rv_core_pkg::REG_ADDR_W-1:0]   i_raddr2,
    output logic [XLEN-1:0]                     o_rdata1,
    output logic [XLEN-1:0]                     o_rdata2
);

    localparam int NUM_REGS = 2 ** rv_core_pkg::REG_ADDR_W;

    // no storage for x0
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

//--- design/rv_operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module rv_operand_bypass #(
    parameter int XLEN = rv_core_pkg::XLEN_DEFAULT
) (
    input  wire [rv_core_pkg::REG_ADDR_W-1:0]   i_rs1,
    input  wire [rv_core_pkg::REG_ADDR_W-1:0]   i_rs2,
    input  wire [XLEN-1:0]                      i_rf_data1,
    input  wire [XLEN-1:0]                      i_rf_data2,
    input  wire                                 i_ex_valid,
    input  wire                                 i_ex_we,
    input  wire [rv_core_pkg::REG_ADDR_W-1:0]   i_ex_rd,
    input  wire [XLEN-1:0]                      i_ex_result,
    input  wire                                 i_wb_valid,
    input  wire                                 i_wb_we,
    input  wire [rv_core_pkg::REG_ADDR_W-1:0]   i_wb_rd,
    input  wire [XLEN-1:0]                      i_wb_result,
    output logic [XLEN-1:0]                     o_op1,
    output logic [XLEN-1:0]                     o_op2
);

    // newest producer wins, the ALU stage is younger than writeback
    function automatic logic [XLEN-1:0] pick(
        input logic [rv_core_pkg::REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]                    rf_data
    );
        logic [XLEN-1:0] value;
        value = rf_data;
        if (rs != '0) begin
            if (i_ex_valid && i_ex_we && (i_ex_rd == rs)) begin
                value = i_ex_result;
            end else if (i_wb_valid && i_wb_we && (i_wb_rd == rs)) begin
                value = i_wb_result;
            end
        end
        return value;
    endfunction

    always_comb begin
        o_op1 = pick(i_rs1, i_rf_data1);
        o_op2 = pick(i_rs2, i_rf_data2);
    end

endmodule

`default_nettype wire

//--- design/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu #(
    parameter int XLEN = rv_core_pkg::XLEN_DEFAULT
) (
    input  wire [rv_core_pkg::ALU_OP_W-1:0] i_alu_op,
    input  wire [XLEN-1:0]                  i_op_a,
    input  wire [XLEN-1:0]                  i_op_b,
    output logic [XLEN-1:0]                 o_result
);

    localparam int SHAMT_W = $clog2(XLEN);

    // 6 bits for RV64, 5 for RV32
    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = i_op_b[SHAMT_W-1:0];
    assign lt_signed   = $signed(i_op_a) < $signed(i_op_b);
    assign lt_unsigned = i_op_a < i_op_b;

    always_comb begin
        case (i_alu_op)
            rv_core_pkg::ALU_ADD: begin
                o_result = i_op_a + i_op_b;
            end
            rv_core_pkg::ALU_SUB: begin
                o_result = i_op_a - i_op_b;
            end
            rv_core_pkg::ALU_SLL: begin
                o_result = i_op_a << shamt;
            end
            rv_core_pkg::ALU_SRL: begin
                o_result = i_op_a >> shamt;
            end
            rv_core_pkg::ALU_SRA: begin
                o_result = $unsigned($signed(i_op_a) >>> shamt);
            end
            rv_core_pkg::ALU_SLT: begin
                o_result = XLEN'(lt_signed);
            end
            rv_core_pkg::ALU_SLTU: begin
                o_result = XLEN'(lt_unsigned);
            end
            rv_core_pkg::ALU_XOR: begin
                o_result = i_op_a ^ i_op_b;
            end
            rv_core_pkg::ALU_OR: begin
                o_result = i_op_a | i_op_b;
            end
            rv_core_pkg::ALU_AND: begin
                o_result = i_op_a & i_op_b;
            end
            rv_core_pkg::ALU_PASS_B: begin
                o_result = i_op_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module rv_int_pipe #(
    parameter int XLEN = rv_core_pkg::XLEN_DEFAULT
) (
    input  wire                                 clk,
    input  wire                                 i_reset,
    input  wire                                 i_instr_valid,
    input  wire rv_core_pkg::instr_t            i_instr,
    output logic                                o_retire_valid,
    output logic                                o_retire_we,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  o_retire_rd,
    output logic [XLEN-1:0]                     o_retire_data
);

    // decode stage
    logic                                 dec_valid;
    rv_core_pkg::instr_t                  dec_instr;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   id_rs1;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   id_rs2;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   id_rd;
    logic [rv_core_pkg::ALU_OP_W-1:0]     id_alu_op;
    logic [XLEN-1:0]                      id_imm;
    logic                                 id_use_imm;
    logic                                 id_reg_we;

    // register read stage
    logic                                 rr_valid;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   rr_rs1;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   rr_rs2;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   rr_rd;
    logic                                 rr_we;
    logic [rv_core_pkg::ALU_OP_W-1:0]     rr_alu_op;
    logic [XLEN-1:0]                      rr_imm;
    logic                                 rr_use_imm;
    logic [XLEN-1:0]                      rf_rdata1;
    logic [XLEN-1:0]                      rf_rdata2;
    logic [XLEN-1:0]                      byp_op1;
    logic [XLEN-1:0]                      byp_op2;

    // ALU stage
    logic                                 ex_valid;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   ex_rd;
    logic                                 ex_we;
    logic [rv_core_pkg::ALU_OP_W-1:0]     ex_alu_op;
    logic [XLEN-1:0]                      ex_imm;
    logic                                 ex_use_imm;
    logic [XLEN-1:0]                      ex_op1;
    logic [XLEN-1:0]                      ex_op2;
    logic [XLEN-1:0]                      ex_op_b;
    logic [XLEN-1:0]                      ex_result;

    // writeback stage
    logic                                 wb_valid;
    logic                                 wb_we;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   wb_rd;
    logic [XLEN-1:0]                      wb_result;
    logic                                 wb_rf_we;

    // nothing stalls, so valid bits simply shift
    always_ff @(posedge clk) begin
        if (i_reset) begin
            dec_valid <= 1'b0;
            rr_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            dec_valid <= i_instr_valid;
            rr_valid  <= dec_valid;
            ex_valid  <= rr_valid;
            wb_valid  <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_instr  <= i_instr;

        rr_rs1     <= id_rs1;
        rr_rs2     <= id_rs2;
        rr_rd      <= id_rd;
        rr_we      <= id_reg_we;
        rr_alu_op  <= id_alu_op;
        rr_imm     <= id_imm;
        rr_use_imm <= id_use_imm;

        ex_rd      <= rr_rd;
        ex_we      <= rr_we;
        ex_alu_op  <= rr_alu_op;
        ex_imm     <= rr_imm;
        ex_use_imm <= rr_use_imm;
        ex_op1     <= byp_op1;
        ex_op2     <= byp_op2;

        wb_rd      <= ex_rd;
        wb_we      <= ex_we;
        wb_result  <= ex_result;
    end

    rv_decoder #(.XLEN(XLEN)) u_decoder (
        .i_instr   (dec_instr),
        .o_rs1     (id_rs1),
        .o_rs2     (id_rs2),
        .o_rd      (id_rd),
        .o_alu_op  (id_alu_op),
        .o_imm     (id_imm),
        .o_use_imm (id_use_imm),
        .o_reg_we  (id_reg_we)
    );

    assign wb_rf_we = wb_valid && wb_we;

    rv_regfile #(.XLEN(XLEN)) u_regfile (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_we     (wb_rf_we),
        .i_waddr  (wb_rd),
        .i_wdata  (wb_result),
        .i_raddr1 (rr_rs1),
        .i_raddr2 (rr_rs2),
        .o_rdata1 (rf_rdata1),
        .o_rdata2 (rf_rdata2)
    );

    // covers distances one and two, the regfile has the rest
    rv_operand_bypass #(.XLEN(XLEN)) u_bypass (
        .i_rs1       (rr_rs1),
        .i_rs2       (rr_rs2),
        .i_rf_data1  (rf_rdata1),
        .i_rf_data2  (rf_rdata2),
        .i_ex_valid  (ex_valid),
        .i_ex_we     (ex_we),
        .i_ex_rd     (ex_rd),
        .i_ex_result (ex_result),
        .i_wb_valid  (wb_valid),
        .i_wb_we     (wb_we),
        .i_wb_rd     (wb_rd),
        .i_wb_result (wb_result),
        .o_op1       (byp_op1),
        .o_op2       (byp_op2)
    );

    assign ex_op_b = ex_use_imm ? ex_imm : ex_op2;

    rv_alu #(.XLEN(XLEN)) u_alu (
        .i_alu_op (ex_alu_op),
        .i_op_a   (ex_op1),
        .i_op_b   (ex_op_b),
        .o_result (ex_result)
    );

    assign o_retire_valid = wb_valid;
    assign o_retire_we    = wb_rf_we;
    assign o_retire_rd    = wb_rd;
    assign o_retire_data  = wb_result;

endmodule

`default_nettype wire

//--- dv/rv_int_pipe_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_int_pipe_asserts (
    input wire                               clk,
    input wire                               i_reset,
    input wire                               i_instr_valid,
    input wire                               i_retire_valid,
    input wire                               i_retire_we,
    input wire [rv_core_pkg::REG_ADDR_W-1:0] i_retire_rd
);

    // stage valid bits clear on reset
    property p_quiet_after_reset;
        @(posedge clk) i_reset |=> !i_retire_valid;
    endproperty

    property p_we_has_rd;
        @(posedge clk) disable iff (i_reset) i_retire_we |-> (i_retire_rd != '0);
    endproperty

    // four stages and no stalls
    property p_retire_latency;
        @(posedge clk) disable iff (i_reset)
            !($past(i_reset, 1) || $past(i_reset, 2) || $past(i_reset, 3) || $past(i_reset, 4))
            |-> (i_retire_valid == $past(i_instr_valid, 4));
    endproperty

    a_quiet_after_reset: assert property (p_quiet_after_reset)
        else $error("retire valid high in the cycle after reset");
    a_we_has_rd: assert property (p_we_has_rd)
        else $error("retire write enable with rd x0");
    a_retire_latency: assert property (p_retire_latency)
        else $error("retire valid does not follow instr valid by 4 cycles");

endmodule

bind rv_int_pipe rv_int_pipe_asserts u_asserts (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_instr_valid  (i_instr_valid),
    .i_retire_valid (o_retire_valid),
    .i_retire_we    (o_retire_we),
    .i_retire_rd    (o_retire_rd)
);

`default_nettype wire

//--- dv/rv_int_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_int_pipe_tb;

    localparam int XLEN = 64;

    logic                                clk;
    logic                                i_reset;
    logic                                i_instr_valid;
    rv_core_pkg::instr_t                 i_instr;
    logic                                o_retire_valid;
    logic                                o_retire_we;
    logic [rv_core_pkg::REG_ADDR_W-1:0]  o_retire_rd;
    logic [XLEN-1:0]                     o_retire_data;

    // architectural state as seen in program order
    logic [XLEN-1:0] model_regs [0:31];

    logic            exp_we_q [$];
    logic [4:0]      exp_rd_q [$];
    logic [XLEN-1:0] exp_data_q [$];
    int              exp_edge_q [$];

    logic [31:0]     seed = 32'hd05dfb34;
    int              edge_count = 0;

    rv_int_pipe #(.XLEN(XLEN)) uut (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_retire_valid (o_retire_valid),
        .o_retire_we    (o_retire_we),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_random(output logic [31:0] value);
        seed = lcg_step(seed);
        value = seed;
    endtask

    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] imm_op(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_core_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] lui_op(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_core_pkg::OP_LUI};
    endfunction

    // RV64I semantics straight from the ISA rules
    function automatic void reference_result(input logic [31:0] w, output logic we,
                                             output logic [4:0] rd,
                                             output logic [XLEN-1:0] data);
        logic [6:0]             opc;
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        logic [5:0]             sh;
        logic signed [XLEN-1:0] sra_val;
        logic                   known;
        opc = w[6:0];
        rd = w[11:7];
        a = model_regs[w[19:15]];
        b = (opc == rv_core_pkg::OP_REG) ? model_regs[w[24:20]] : {{52{w[31]}}, w[31:20]};
        sh = b[5:0];
        sra_val = $signed(a) >>> sh;
        known = 1'b1;
        data = '0;
        if (opc == rv_core_pkg::OP_LUI) begin
            data = {{32{w[31]}}, w[31:12], 12'h000};
        end else if (opc == rv_core_pkg::OP_REG || opc == rv_core_pkg::OP_IMM) begin
            case (w[14:12])
                rv_core_pkg::FUNCT3_ADD_SUB:
                    data = (opc == rv_core_pkg::OP_REG && w[30]) ? a - b : a + b;
                rv_core_pkg::FUNCT3_SLL:     data = a << sh;
                rv_core_pkg::FUNCT3_SLT:     data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                rv_core_pkg::FUNCT3_SLTU:    data = (a < b) ? 64'd1 : 64'd0;
                rv_core_pkg::FUNCT3_XOR:     data = a ^ b;
                rv_core_pkg::FUNCT3_SRL_SRA: data = w[30] ? sra_val : (a >> sh);
                rv_core_pkg::FUNCT3_OR:      data = a | b;
                default:                     data = a & b;
            endcase
        end else begin
            known = 1'b0;
        end
        we = known && (rd != 5'd0);
    endfunction

    task automatic send(input logic [31:0] word);
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        reference_result(word, we, rd, data);
        exp_we_q.push_back(we);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
        // accepted at the coming rising edge
        exp_edge_q.push_back(edge_count + 1);
        if (we) begin
            model_regs[rd] = data;
        end
        i_instr_valid = 1'b1;
        i_instr = word;
        @(negedge clk);
        i_instr_valid = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // registers x0..x7 only, so dependencies come often
    task automatic random_instr(output logic [31:0] word);
        logic [31:0] r;
        logic [31:0] f;
        logic [11:0] imm;
        int          sel;
        next_random(r);
        next_random(f);
        imm = f[19:8];
        sel = int'(r[31:27]);
        if (sel < 12) begin
            word = reg_op((f[7] && (f[22:20] == 3'b000 || f[22:20] == 3'b101)) ? 7'h20 : 7'h00,
                          {2'b00, f[25:23]}, {2'b00, f[28:26]}, f[22:20], {2'b00, f[31:29]});
        end else if (sel < 26) begin
            if (f[22:20] == 3'b001) begin
                imm = {6'b000000, imm[5:0]};
            end else if (f[22:20] == 3'b101) begin
                imm = {1'b0, f[7], 4'b0000, imm[5:0]};
            end
            word = imm_op(imm, {2'b00, f[28:26]}, f[22:20], {2'b00, f[31:29]});
        end else if (sel < 30) begin
            word = lui_op(r[26:7], {2'b00, f[31:29]});
        end else begin
            // load or store opcode, dropped from this core
            word = {f[31:7], r[0] ? 7'b0000011 : 7'b0100011};
        end
    endtask

    always @(posedge clk) begin
        edge_count++;
        if (!i_reset && o_retire_valid) begin
            if (exp_we_q.size() == 0) begin
                $display("retirement at %0t ns with no instruction outstanding", $time);
                stop_with_failure();
            end else begin
                check_value("retire edge", 64'(edge_count), 64'(exp_edge_q.pop_front() + 4));
                check_value("o_retire_we", 64'(o_retire_we), 64'(exp_we_q.pop_front()));
                check_value("o_retire_rd", 64'(o_retire_rd), 64'(exp_rd_q.pop_front()));
                check_value("o_retire_data", o_retire_data, exp_data_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] r;
        int          wait_cycles;
        i_reset = 1'b1;
        i_instr_valid = 1'b0;
        i_instr = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        idle(2);
        i_reset = 1'b0;

        // first instruction alone in the pipe
        idle(3);
        send(imm_op(12'h123, 5'd0, rv_core_pkg::FUNCT3_ADD_SUB, 5'd1));
        idle(6);

        // every operation, negative operands, back to back
        send(imm_op(12'hf9c, 5'd0, rv_core_pkg::FUNCT3_ADD_SUB, 5'd2));
        send(imm_op(12'h007, 5'd0, rv_core_pkg::FUNCT3_ADD_SUB, 5'd3));
        send(reg_op(7'h20, 5'd2, 5'd3, rv_core_pkg::FUNCT3_ADD_SUB, 5'd4));
        send(reg_op(7'h20, 5'd3, 5'd2, rv_core_pkg::FUNCT3_ADD_SUB, 5'd5));
        send(reg_op(7'h20, 5'd3, 5'd5, rv_core_pkg::FUNCT3_SRL_SRA, 5'd6));
        send(imm_op(12'h402, 5'd2, rv_core_pkg::FUNCT3_SRL_SRA, 5'd7));
        send(reg_op(7'h00, 5'd3, 5'd2, rv_core_pkg::FUNCT3_SRL_SRA, 5'd6));
        send(imm_op(12'h004, 5'd2, rv_core_pkg::FUNCT3_SRL_SRA, 5'd7));
        send(reg_op(7'h00, 5'd3, 5'd3, rv_core_pkg::FUNCT3_SLL, 5'd6));
        send(imm_op(12'h03f, 5'd2, rv_core_pkg::FUNCT3_SLL, 5'd7));
        send(reg_op(7'h00, 5'd3, 5'd2, rv_core_pkg::FUNCT3_SLT, 5'd6));
        send(reg_op(7'h00, 5'd3, 5'd2, rv_core_pkg::FUNCT3_SLTU, 5'd7));
        send(imm_op(12'h001, 5'd2, rv_core_pkg::FUNCT3_SLT, 5'd6));
        send(imm_op(12'hfff, 5'd3, rv_core_pkg::FUNCT3_SLTU, 5'd7));
        send(reg_op(7'h00, 5'd3, 5'd2, rv_core_pkg::FUNCT3_XOR, 5'd6));
        send(reg_op(7'h00, 5'd3, 5'd2, rv_core_pkg::FUNCT3_OR, 5'd7));
        send(reg_op(7'h00, 5'd3, 5'd2, rv_core_pkg::FUNCT3_AND, 5'd6));
        send(imm_op(12'h0ff, 5'd2, rv_core_pkg::FUNCT3_XOR, 5'd7));
        send(imm_op(12'h800, 5'd3, rv_core_pkg::FUNCT3_OR, 5'd6));
        send(imm_op(12'h0f0, 5'd2, rv_core_pkg::FUNCT3_AND, 5'd7));
        send(lui_op(20'h80001, 5'd5));
        send(imm_op(12'h41f, 5'd5, rv_core_pkg::FUNCT3_SRL_SRA, 5'd6));

        // dependency distances one, two and three
        send(imm_op(12'h00a, 5'd0, rv_core_pkg::FUNCT3_ADD_SUB, 5'd1));
        send(reg_op(7'h20, 5'd1, 5'd0, rv_core_pkg::FUNCT3_ADD_SUB, 5'd2));
        send(reg_op(7'h00, 5'd0, 5'd1, rv_core_pkg::FUNCT3_ADD_SUB, 5'd3));
        send(reg_op(7'h00, 5'd1, 5'd2, rv_core_pkg::FUNCT3_SLT, 5'd4));
        send(reg_op(7'h00, 5'd3, 5'd4, rv_core_pkg::FUNCT3_ADD_SUB, 5'd5));

        // x0 as destination must not be forwarded
        send(imm_op(12'h005, 5'd1, rv_core_pkg::FUNCT3_ADD_SUB, 5'd0));
        send(reg_op(7'h00, 5'd1, 5'd0, rv_core_pkg::FUNCT3_ADD_SUB, 5'd6));
        send(reg_op(7'h00, 5'd0, 5'd0, rv_core_pkg::FUNCT3_OR, 5'd7));

        // ld x2 and ecall, then a read of x2
        send(32'h0000_b103);
        send(32'h0000_0073);
        send(reg_op(7'h00, 5'd0, 5'd2, rv_core_pkg::FUNCT3_ADD_SUB, 5'd6));

        for (int n = 0; n < 400; n++) begin
            random_instr(word);
            send(word);
            next_random(r);
            if (r[31:30] == 2'b00) begin
                idle(int'(r[29:28]) + 1);
            end
        end

        wait_cycles = 0;
        while (exp_we_q.size() != 0 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (exp_we_q.size() != 0) begin
            $display("timeout: %0d instructions never retired", exp_we_q.size());
            stop_with_failure();
        end else begin
            // no extra retirements after the last one
            idle(8);
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- list.f
design/rv_core_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_operand_bypass.sv
design/rv_alu.sv
design/rv_int_pipe.sv
dv/rv_int_pipe_asserts.sv
dv/rv_int_pipe_tb.sv

//--- run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rv_int_pipe_tb -f list.f -o rv_int_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/rv_int_pipe_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed!"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
